// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FLIST     ?= ex_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; \
	echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== ex_stage.f ====
hw/ex_pkg.sv
hw/ex_operands.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_stage_regs.sv
hw/ex_stage.sv
verification/ex_stage_sva.sv
verification/tb_ex_stage.sv

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_opc_t           opc,
    input  logic [ex_pkg::data_w-1:0] src_val,
    input  logic [ex_pkg::data_w-1:0] tgt_val,
    input  logic [ex_pkg::data_w-1:0] imm_zx,
    input  logic [ex_pkg::data_w-1:0] imm_up,
    input  logic [ex_pkg::data_w-1:0] imm_sx,
    input  ex_pkg::ex_flags_t         flags,
    output logic [ex_pkg::data_w-1:0] result,
    output logic [ex_pkg::addr_w-1:0] addr,
    output ex_pkg::ex_flags_t         flags_next,
    output logic [3:0]                flags_we,
    output logic                      upper_we
);
    import ex_pkg::*;

    logic [data_w-1:0] opnd;        // Second operand against tgt_val
    logic [data_w-1:0] cmp_diff;    // Compare difference for the flags only
    logic [data_w-1:0] flag_src;
    logic [data_w-1:0] sra_val;
    logic              over;        // Shift amount saturates
    ex_flags_t         fl_cv;

    function automatic logic add_ovf(input logic [data_w-1:0] a, b, r);
        return ~(a[data_w-1] ^ b[data_w-1]) & (a[data_w-1] ^ r[data_w-1]);
    endfunction

    function automatic logic sub_ovf(input logic [data_w-1:0] a, b, r);
        return (a[data_w-1] ^ b[data_w-1]) & (a[data_w-1] ^ r[data_w-1]);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (opc)
            opc_moviu, opc_addiu, opc_subiu, opc_andiu, opc_oriu, opc_xoriu,
            opc_shliu, opc_shriu, opc_cmpiu, opc_stiu:
                opnd = imm_up;
            opc_movis, opc_addis, opc_subis, opc_cmpis, opc_stis:
                opnd = imm_sx;
            opc_shris: opnd = imm_zx;                   // Never a negative amount
            default:   opnd = src_val;
        endcase
    end

    assign over     = opnd >= data_w'(shift_limit);
    assign sra_val  = $signed(tgt_val) >>> opnd[shamt_w-1:0];
    assign flag_src = result | cmp_diff;                // At most one is nonzero

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compares take tgt_val minus opnd like SUB
    always_comb begin
        result   = '0;
        addr     = '0;
        cmp_diff = '0;
        fl_cv    = flags;
        flags_we = '0;
        upper_we = 1'b0;
        case (opc)
            opc_movu, opc_moviu, opc_movis: begin
                result   = opnd;
                flags_we = fl_we_z;
            end
            opc_addu, opc_addiu: begin
                {fl_cv.c, result} = {1'b0, tgt_val} + {1'b0, opnd};
                flags_we          = fl_we_z | fl_we_c;
            end
            opc_subu, opc_subiu: begin
                result   = tgt_val - opnd;
                fl_cv.c  = tgt_val < opnd;              // Borrow
                flags_we = fl_we_z | fl_we_c;
            end
            opc_cmpu, opc_cmpiu: begin
                cmp_diff = tgt_val - opnd;
                fl_cv.c  = tgt_val < opnd;
                flags_we = fl_we_z | fl_we_c;
            end
            opc_notu: begin
                result   = ~tgt_val;
                flags_we = fl_we_z;
            end
            opc_andu, opc_andiu: begin
                result   = tgt_val & opnd;
                flags_we = fl_we_z;
            end
            opc_oru, opc_oriu: begin
                result   = tgt_val | opnd;
                flags_we = fl_we_z;
            end
            opc_xoru, opc_xoriu: begin
                result   = tgt_val ^ opnd;
                flags_we = fl_we_z;
            end
            opc_shlu, opc_shliu: begin
                result   = over ? '0 : tgt_val << opnd[shamt_w-1:0];
                fl_cv.v  = over;
                flags_we = fl_we_z | fl_we_v;
            end
            opc_shru, opc_shriu: begin
                result   = over ? '0 : tgt_val >> opnd[shamt_w-1:0];
                fl_cv.v  = over;
                flags_we = fl_we_z | fl_we_v;
            end
            opc_shrs, opc_shris: begin
                result   = over ? '0 : sra_val;
                fl_cv.v  = over;
                flags_we = fl_we_z | fl_we_n | fl_we_v;
            end
            opc_adds, opc_addis: begin
                result   = tgt_val + opnd;
                fl_cv.v  = add_ovf(tgt_val, opnd, result);
                flags_we = fl_we_z | fl_we_n | fl_we_v;
            end
            opc_subs, opc_subis: begin
                result   = tgt_val - opnd;
                fl_cv.v  = sub_ovf(tgt_val, opnd, result);
                flags_we = fl_we_z | fl_we_n | fl_we_v;
            end
            opc_cmps, opc_cmpis: begin
                cmp_diff = tgt_val - opnd;
                fl_cv.v  = sub_ovf(tgt_val, opnd, cmp_diff);
                flags_we = fl_we_z | fl_we_n | fl_we_v;
            end
            opc_lui: upper_we = 1'b1;
            opc_ldu: addr = src_val;
            opc_stu, opc_stiu, opc_stis: begin
                addr   = tgt_val;
                result = opnd;                          // Store data
            end
            default: ;                                  // Branches and unknown opcodes
        endcase
    end

    // z and n come from whichever value the opcode produced
    always_comb begin
        flags_next = fl_cv;
        if (|(flags_we & fl_we_z)) begin
            flags_next.z = ~|flag_src;
        end
        if (|(flags_we & fl_we_n)) begin
            flags_next.n = flag_src[data_w-1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  ex_pkg::ex_opc_t           opc,
    input  ex_pkg::ex_cc_t            cc,
    input  logic [ex_pkg::addr_w-1:0] pc,
    input  logic [ex_pkg::data_w-1:0] src_val,
    input  logic [ex_pkg::data_w-1:0] imm_up,
    input  logic [ex_pkg::data_w-1:0] imm_sx,
    input  ex_pkg::ex_flags_t         flags,
    output logic                      taken,
    output logic [ex_pkg::addr_w-1:0] target
);
    import ex_pkg::*;

    logic              cond;
    logic              is_branch;
    logic [addr_w-1:0] dest;

    // Signed codes use n and v, unsigned ones use c
    always_comb begin
        case (cc)
            cc_ra:   cond = 1'b1;
            cc_eq:   cond = flags.z;
            cc_ne:   cond = ~flags.z;
            cc_lt:   cond = flags.n ^ flags.v;
            cc_gt:   cond = ~flags.z & ~(flags.n ^ flags.v);
            cc_ge:   cond = ~(flags.n ^ flags.v);
            cc_le:   cond = flags.z | (flags.n ^ flags.v);
            cc_bt:   cond = flags.c;
            cc_at:   cond = ~flags.z & ~flags.c;
            cc_be:   cond = flags.c | flags.z;
            cc_ae:   cond = ~flags.c;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        is_branch = 1'b1;
        case (opc)
            opc_jccu:  dest = pc + src_val;             // Register relative
            opc_jcciu: dest = imm_up;                   // Absolute
            opc_bccis: dest = pc + imm_sx;
            default: begin
                is_branch = 1'b0;
                dest      = '0;
            end
        endcase
    end

    assign taken  = is_branch & cond;
    assign target = taken ? dest : '0;

endmodule

`default_nettype wire

// ==== hw/ex_operands.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_operands (
    input  logic [ex_pkg::imm_w-1:0]  imm,
    input  logic [ex_pkg::imm_w-1:0]  upper,
    output logic [ex_pkg::data_w-1:0] imm_zx,
    output logic [ex_pkg::data_w-1:0] imm_up,
    output logic [ex_pkg::data_w-1:0] imm_sx
);
    import ex_pkg::*;

    // Plain zero extension, used as a shift amount
    assign imm_zx = {{(data_w - imm_w){1'b0}}, imm};

    // Upper half comes from the last LUI
    assign imm_up = {upper, imm};

    assign imm_sx = {{(data_w - imm_w){imm[imm_w-1]}}, imm};

endmodule

`default_nettype wire

// ==== hw/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int data_w      = 24;
    localparam int addr_w      = 24;
    localparam int imm_w       = 12;
    localparam int reg_idx_w   = 4;
    localparam int shift_limit = 24;                    // Shift amounts from here on give 0
    localparam int shamt_w     = $clog2(shift_limit);

    // Flag write mask, same bit order as ex_flags_t
    localparam logic [3:0] fl_we_z = 4'b1000;
    localparam logic [3:0] fl_we_n = 4'b0100;
    localparam logic [3:0] fl_we_c = 4'b0010;
    localparam logic [3:0] fl_we_v = 4'b0001;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes, grouped by register/immediate and unsigned/signed
    typedef enum logic [5:0] {
        opc_unk   = 6'h00,                              // Reset and bubbles
        opc_movu  = 6'h01, opc_addu  = 6'h02, opc_subu  = 6'h03,
        opc_notu  = 6'h04, opc_andu  = 6'h05, opc_oru   = 6'h06,
        opc_xoru  = 6'h07, opc_shlu  = 6'h08, opc_shru  = 6'h09,
        opc_cmpu  = 6'h0a, opc_jccu  = 6'h0b, opc_ldu   = 6'h0c,
        opc_stu   = 6'h0d, opc_lui   = 6'h0e,
        opc_adds  = 6'h10, opc_subs  = 6'h11, opc_shrs  = 6'h12,
        opc_cmps  = 6'h13,
        opc_moviu = 6'h18, opc_addiu = 6'h19, opc_subiu = 6'h1a,
        opc_andiu = 6'h1b, opc_oriu  = 6'h1c, opc_xoriu = 6'h1d,
        opc_shliu = 6'h1e, opc_shriu = 6'h1f, opc_cmpiu = 6'h20,
        opc_jcciu = 6'h21, opc_stiu  = 6'h22,
        opc_movis = 6'h28, opc_addis = 6'h29, opc_subis = 6'h2a,
        opc_shris = 6'h2b, opc_cmpis = 6'h2c, opc_bccis = 6'h2d,
        opc_stis  = 6'h2e
    } ex_opc_t;

    typedef enum logic [3:0] {
        cc_ra = 4'h0, cc_eq = 4'h1, cc_ne = 4'h2, cc_lt = 4'h3,
        cc_gt = 4'h4, cc_ge = 4'h5, cc_le = 4'h6, cc_bt = 4'h7,
        cc_at = 4'h8, cc_be = 4'h9, cc_ae = 4'ha
    } ex_cc_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } ex_flags_t;

    typedef struct packed {
        logic [addr_w-1:0]    pc;
        ex_opc_t              opc;
        ex_cc_t               cc;
        logic [reg_idx_w-1:0] tgt_gp;
        logic                 tgt_gp_we;
        logic [imm_w-1:0]     imm;
    } ex_issue_t;

    typedef struct packed {
        logic [addr_w-1:0]    pc;
        ex_opc_t              opc;
        logic [reg_idx_w-1:0] tgt_gp;
        logic                 tgt_gp_we;
        logic [addr_w-1:0]    addr;
        logic [data_w-1:0]    result;
        logic                 branch_taken;
        logic [addr_w-1:0]    branch_pc;
    } ex_result_t;

endpackage

`default_nettype wire

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                      iw_clk,
    input  logic                      iw_rst,
    input  ex_pkg::ex_issue_t         issue,
    input  logic [ex_pkg::data_w-1:0] src_val,
    input  logic [ex_pkg::data_w-1:0] tgt_val,
    input  logic                      flush,
    input  logic                      stall,
    output ex_pkg::ex_result_t        out
);
    import ex_pkg::*;

    logic [data_w-1:0] imm_zx;
    logic [data_w-1:0] imm_up;
    logic [data_w-1:0] imm_sx;
    logic [imm_w-1:0]  upper;
    ex_flags_t         flags;
    ex_flags_t         flags_next;
    logic [3:0]        flags_we;
    logic              upper_we;
    logic [data_w-1:0] alu_result;
    logic [addr_w-1:0] alu_addr;
    logic              taken;
    logic [addr_w-1:0] target;

    ex_operands u_operands (
        .imm    (issue.imm),
        .upper  (upper),
        .imm_zx (imm_zx),
        .imm_up (imm_up),
        .imm_sx (imm_sx)
    );

    ex_alu u_alu (
        .opc        (issue.opc),
        .src_val    (src_val),
        .tgt_val    (tgt_val),
        .imm_zx     (imm_zx),
        .imm_up     (imm_up),
        .imm_sx     (imm_sx),
        .flags      (flags),
        .result     (alu_result),
        .addr       (alu_addr),
        .flags_next (flags_next),
        .flags_we   (flags_we),
        .upper_we   (upper_we)
    );

    ex_branch u_branch (
        .opc     (issue.opc),
        .cc      (issue.cc),
        .pc      (issue.pc),
        .src_val (src_val),
        .imm_up  (imm_up),
        .imm_sx  (imm_sx),
        .flags   (flags),
        .taken   (taken),
        .target  (target)
    );

    ex_stage_regs u_regs (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .flush      (flush),
        .stall      (stall),
        .issue      (issue),
        .alu_result (alu_result),
        .alu_addr   (alu_addr),
        .flags_next (flags_next),
        .flags_we   (flags_we),
        .upper_we   (upper_we),
        .taken      (taken),
        .target     (target),
        .flags      (flags),
        .upper      (upper),
        .out        (out)
    );

endmodule

`default_nettype wire

// ==== hw/ex_stage_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_regs (
    input  logic                      iw_clk,
    input  logic                      iw_rst,
    input  logic                      flush,
    input  logic                      stall,
    input  ex_pkg::ex_issue_t         issue,
    input  logic [ex_pkg::data_w-1:0] alu_result,
    input  logic [ex_pkg::addr_w-1:0] alu_addr,
    input  ex_pkg::ex_flags_t         flags_next,
    input  logic [3:0]                flags_we,
    input  logic                      upper_we,
    input  logic                      taken,
    input  logic [ex_pkg::addr_w-1:0] target,
    output ex_pkg::ex_flags_t         flags,
    output logic [ex_pkg::imm_w-1:0]  upper,
    output ex_pkg::ex_result_t        out
);
    import ex_pkg::*;

    logic       accept;
    ex_result_t out_next;

    // Flush and stall both turn the slot into a bubble
    assign accept = ~(flush | stall);

    always_comb begin
        out_next.pc           = issue.pc;
        out_next.opc          = issue.opc;
        out_next.tgt_gp       = issue.tgt_gp;
        out_next.tgt_gp_we    = issue.tgt_gp_we;
        out_next.addr         = alu_addr;
        out_next.result       = alu_result;
        out_next.branch_taken = taken;
        out_next.branch_pc    = target;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            flags <= '0;
            upper <= '0;
            out   <= '0;
        end else if (accept) begin
            flags <= ex_flags_t'((flags & ~flags_we) | (flags_next & flags_we));
            if (upper_we) begin
                upper <= issue.imm;
            end
            out <= out_next;
        end else begin
            out <= '0;                                  // Flags and upper hold
        end
    end

endmodule

`default_nettype wire

// ==== verification/ex_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_sva (
    input logic               iw_clk,
    input logic               iw_rst,
    input logic               flush,
    input logic               stall,
    input ex_pkg::ex_result_t out
);
    import ex_pkg::*;

    a_reset_zero: assert property (@(posedge iw_clk) iw_rst |=> out == '0)
        else $error("out not zero after reset");

    // Either level discards the slot
    a_bubble: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (flush || stall) |=> out == '0)
        else $error("no bubble after flush or stall");

    a_taken_branch: assert property (@(posedge iw_clk) disable iff (iw_rst)
        out.branch_taken |-> out.opc inside {opc_jccu, opc_jcciu, opc_bccis})
        else $error("branch_taken on a non-branch opcode");

endmodule

`default_nettype wire

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int n_cycles = 2 + 38 + 6 + 8 + 44 + 4 + 6 + 2;    // Sum over the tests

    logic       iw_clk = 1'b0;
    logic       iw_rst = 1'b1;
    ex_issue_t  issue = '0;
    logic [data_w-1:0] src_val = '0;
    logic [data_w-1:0] tgt_val = '0;
    logic       flush = 1'b0;
    logic       stall = 1'b0;
    ex_result_t out;

    ex_flags_t        m_flags = '0;     // Reference copy of the flag register
    logic [imm_w-1:0] m_upper = '0;
    ex_result_t       pend_exp;
    string            pend_name;
    logic             pend_valid = 1'b0;
    int               errors = 0;
    int               n_checks = 0;

    ex_stage u_ex_stage (.*);

    bind ex_stage ex_stage_sva u_sva (.*);

    always #2 iw_clk = ~iw_clk;

    task automatic check(string name, ex_result_t expected, ex_result_t actual);
        n_checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic cond_met(ex_cc_t cc, ex_flags_t f);
        case (cc)
            cc_ra:   return 1'b1;
            cc_eq:   return f.z;
            cc_ne:   return !f.z;
            cc_lt:   return f.n != f.v;
            cc_gt:   return !f.z && f.n == f.v;
            cc_ge:   return f.n == f.v;
            cc_le:   return f.z || f.n != f.v;
            cc_bt:   return f.c;
            cc_at:   return !f.z && !f.c;
            cc_be:   return f.c || f.z;
            cc_ae:   return !f.c;
            default: return 1'b0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One instruction per cycle and a check of the previous one at the falling edge
    task automatic step(string name, ex_opc_t opc, ex_cc_t cc, logic [imm_w-1:0] imm,
                        logic [data_w-1:0] src, logic [data_w-1:0] tgt,
                        logic fl = 1'b0, logic st = 1'b0);
        ex_issue_t         iss;
        ex_result_t        e;
        ex_flags_t         nf;
        logic [3:0]        we;
        logic [data_w-1:0] b, r, d;
        logic              tk;
        iss = '{pc: 24'($urandom), opc: opc, cc: cc, tgt_gp: 4'($urandom),
                tgt_gp_we: 1'($urandom), imm: imm};
        @(posedge iw_clk);
        issue   <= iss;
        src_val <= src;
        tgt_val <= tgt;
        flush   <= fl;
        stall   <= st;
        @(negedge iw_clk);
        if (pend_valid) check(pend_name, pend_exp, out);
        b = src;
        if (opc inside {opc_moviu, opc_addiu, opc_subiu, opc_andiu, opc_oriu, opc_xoriu,
                        opc_shliu, opc_shriu, opc_cmpiu, opc_stiu})
            b = {m_upper, imm};
        else if (opc inside {opc_movis, opc_addis, opc_subis, opc_cmpis, opc_stis})
            b = {{(data_w - imm_w){imm[imm_w-1]}}, imm};
        else if (opc == opc_shris)
            b = {{(data_w - imm_w){1'b0}}, imm};
        r  = '0;
        d  = '0;
        nf = m_flags;
        we = 4'b0000;
        e  = '{pc: iss.pc, opc: opc, tgt_gp: iss.tgt_gp, tgt_gp_we: iss.tgt_gp_we, default: '0};
        // Flags written per opcode class, in z n c v order
        if (opc inside {opc_movu, opc_moviu, opc_movis, opc_notu, opc_andu, opc_andiu,
                        opc_oru, opc_oriu, opc_xoru, opc_xoriu})
            we = 4'b1000;
        else if (opc inside {opc_addu, opc_addiu, opc_subu, opc_subiu, opc_cmpu, opc_cmpiu})
            we = 4'b1010;
        else if (opc inside {opc_shlu, opc_shliu, opc_shru, opc_shriu})
            we = 4'b1001;
        else if (opc inside {opc_shrs, opc_shris, opc_adds, opc_addis, opc_subs, opc_subis,
                             opc_cmps, opc_cmpis})
            we = 4'b1101;
        case (opc)
            opc_movu, opc_moviu, opc_movis: r = b;
            opc_addu, opc_addiu: {nf.c, r} = {1'b0, tgt} + {1'b0, b};
            opc_subu, opc_subiu: begin
                r    = tgt - b;
                nf.c = tgt < b;
            end
            opc_cmpu, opc_cmpiu: begin
                d    = tgt - b;
                nf.c = tgt < b;
            end
            opc_notu: r = ~tgt;
            opc_andu, opc_andiu: r = tgt & b;
            opc_oru, opc_oriu: r = tgt | b;
            opc_xoru, opc_xoriu: r = tgt ^ b;
            opc_shlu, opc_shliu, opc_shru, opc_shriu, opc_shrs, opc_shris: begin
                nf.v = b >= 24'(shift_limit);
                if (nf.v) r = '0;
                else if (opc inside {opc_shlu, opc_shliu}) r = tgt << b;
                else if (opc inside {opc_shru, opc_shriu}) r = tgt >> b;
                else r = 24'($signed(tgt) >>> b);
            end
            opc_adds, opc_addis: begin
                r    = tgt + b;
                nf.v = tgt[23] == b[23] && r[23] != tgt[23];
            end
            opc_subs, opc_subis, opc_cmps, opc_cmpis: begin
                d    = tgt - b;
                nf.v = tgt[23] != b[23] && d[23] != tgt[23];
                if (opc inside {opc_subs, opc_subis}) begin
                    r = d;
                    d = '0;
                end
            end
            opc_ldu: e.addr = src;
            opc_stu, opc_stiu, opc_stis: begin
                e.addr = tgt;
                r      = b;
            end
            opc_jccu, opc_jcciu, opc_bccis: begin
                tk = cond_met(cc, m_flags);
                e.branch_taken = tk;
                if (tk && opc == opc_jccu) e.branch_pc = iss.pc + src;
                if (tk && opc == opc_jcciu) e.branch_pc = {m_upper, imm};
                if (tk && opc == opc_bccis) e.branch_pc = iss.pc + {{12{imm[11]}}, imm};
            end
            default: ;
        endcase
        e.result = r;
        nf.z = ~|(r | d);
        nf.n = r[data_w-1] | d[data_w-1];
        if (fl || st) begin
            e = '0;                                     // Bubble and the state holds
        end else begin
            m_flags = ex_flags_t'((m_flags & ~we) | (nf & we));
            if (opc == opc_lui) m_upper = imm;
        end
        pend_exp   = e;
        pend_name  = name;
        pend_valid = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_unsigned_alu();
        ex_opc_t reg_ops[$] = '{opc_movu, opc_addu, opc_subu, opc_notu, opc_andu,
                                opc_oru, opc_xoru, opc_shlu, opc_shru, opc_cmpu};
        ex_opc_t imm_ops[$] = '{opc_moviu, opc_addiu, opc_subiu, opc_andiu, opc_oriu,
                                opc_xoriu, opc_shliu, opc_shriu, opc_cmpiu};
        repeat (2) begin
            foreach (reg_ops[i])
                step("unsigned_reg", reg_ops[i], cc_ra, '0, 24'($urandom % 30), 24'($urandom));
            foreach (imm_ops[i])
                step("unsigned_imm", imm_ops[i], cc_ra, 12'($urandom), '0, 24'($urandom));
        end
    endtask

    task automatic test_lui();
        step("lui", opc_lui, cc_ra, 12'habc, '0, '0);
        step("lui_addiu", opc_addiu, cc_ra, 12'h123, '0, 24'($urandom));
        step("lui_oriu", opc_oriu, cc_ra, 12'h00f, '0, 24'($urandom));
        step("movis", opc_movis, cc_ra, 12'h9f0, '0, '0);
        step("addis", opc_addis, cc_ra, 12'h801, '0, 24'($urandom));
        step("subis", opc_subis, cc_ra, 12'hfff, '0, 24'h7fffff);
    endtask

    task automatic test_shifts();
        step("shlu_small", opc_shlu, cc_ra, '0, 24'd5, 24'($urandom));
        step("shlu_limit", opc_shlu, cc_ra, '0, 24'd24, 24'($urandom));
        step("v_lt", opc_bccis, cc_lt, 12'h010, '0, '0);
        step("shrs_small", opc_shrs, cc_ra, '0, 24'd3, 24'h900000);
        step("v_ge", opc_bccis, cc_ge, 12'hff0, '0, '0);
        step("shris_big", opc_shris, cc_ra, 12'h800, '0, 24'h800000);
        step("v_lt_again", opc_bccis, cc_lt, 12'h020, '0, '0);
        step("shru_small", opc_shru, cc_ra, '0, 24'd23, 24'hffffff);
    endtask

    task automatic test_branches();
        for (int i = 0; i < 11; i++) begin
            if (i % 2 == 0)
                step("cmpu", opc_cmpu, cc_ra, '0, 24'($urandom % 4), 24'($urandom % 4));
            else
                step("cmps", opc_cmps, cc_ra, '0, 24'($urandom), 24'($urandom));
            step("jccu", opc_jccu, ex_cc_t'(i), '0, 24'($urandom), '0);
            step("jcciu", opc_jcciu, ex_cc_t'(i), 12'($urandom), '0, '0);
            step("bccis", opc_bccis, ex_cc_t'(i), 12'($urandom), '0, '0);
        end
    endtask

    task automatic test_memory();
        step("ldu", opc_ldu, cc_ra, '0, 24'($urandom), 24'($urandom));
        step("stu", opc_stu, cc_ra, '0, 24'($urandom), 24'($urandom));
        step("stiu", opc_stiu, cc_ra, 12'($urandom), '0, 24'($urandom));
        step("stis", opc_stis, cc_ra, 12'hf80, '0, 24'($urandom));
    endtask

    task automatic test_bubbles();
        step("cmp_equal", opc_cmpu, cc_ra, '0, 24'h42, 24'h42);
        step("flushed_sub", opc_subu, cc_ra, '0, 24'h1, 24'h5, 1'b1, 1'b0);
        step("stalled_sub", opc_subu, cc_ra, '0, 24'h1, 24'h5, 1'b0, 1'b1);
        step("both_high", opc_lui, cc_ra, 12'h555, '0, '0, 1'b1, 1'b1);
        step("eq_after_bubble", opc_bccis, cc_eq, 12'h004, '0, '0);
        step("jcciu_upper", opc_jcciu, cc_ra, 12'h321, '0, '0);
    endtask

    initial begin
        #((n_cycles + 100) * 4);
        $display("Timeout: the tests did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(73472));
        repeat (2) @(posedge iw_clk);
        iw_rst <= 1'b0;
        test_unsigned_alu();
        test_lui();
        test_shifts();
        test_branches();
        test_memory();
        test_bubbles();
        step("drain", opc_unk, cc_ra, '0, '0, '0);
        step("drain", opc_unk, cc_ra, '0, '0, '0);
        $display("Done: %0d checks, %0d errors", n_checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
